// ==== compile.f ====
rtl/minimig_de1_pkg.sv
rtl/board_io.sv
rtl/audio_mixer.sv
rtl/audio_shifter.sv
rtl/indicators.sv
rtl/minimig_de1_glue.sv
dv/tb_minimig_de1_glue.sv

// ==== Bender.yml ====
package:
  name: minimig_de1_glue

sources:
  - rtl/minimig_de1_pkg.sv
  - rtl/board_io.sv
  - rtl/audio_mixer.sv
  - rtl/audio_shifter.sv
  - rtl/indicators.sv
  - rtl/minimig_de1_glue.sv
  - target: simulation
    files:
      - dv/tb_minimig_de1_glue.sv

// ==== dv/tb_minimig_de1_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_minimig_de1_glue;

  localparam int  N_CFG        = 8;                      // Random switch settings
  localparam int  PAIRS_PER    = 4;                      // Pairs per exchan/mix setting
  localparam int  N_FRAMES     = 4 * PAIRS_PER;
  localparam int  FRAME_CYCLES = 4 * minimig_de1_pkg::CHAN_BITS * minimig_de1_pkg::BCLK_HALF;
  localparam int  MAX_CYCLES   = N_FRAMES * FRAME_CYCLES + 1000; // Margin for the other tests
  localparam time DRIVE_DLY    = 1ns;

  logic                     clk;
  logic                     rst_n;
  logic [9:0]               sw;
  logic [3:0]               key;
  logic                     spi_cs0_n;
  logic                     sd_dat;
  logic                     core_sdo;
  logic                     spi_di;
  logic                     scandoubler_dis;
  logic                     joy_emu_en;
  logic                     boot_sel;
  logic                     rst_ext;
  minimig_de1_pkg::nibble_t ctrl_cfg;
  logic                     sample_valid;
  minimig_de1_pkg::sample_t ldata;
  minimig_de1_pkg::sample_t rdata;
  logic                     sample_credit;
  logic                     aud_bclk;
  logic                     aud_daclrck;
  logic                     aud_dacdat;
  minimig_de1_pkg::track_t  track;
  logic                     floppy_fwr;
  logic                     floppy_frd;
  logic                     hd_fwr;
  logic                     hd_frd;
  minimig_de1_pkg::nibble_t ctrl_status;
  logic                     rom_status;
  logic                     ram_status;
  logic                     reg_status;
  minimig_de1_pkg::seg7_t   hex0;
  minimig_de1_pkg::seg7_t   hex1;
  minimig_de1_pkg::seg7_t   hex2;
  minimig_de1_pkg::seg7_t   hex3;
  minimig_de1_pkg::led_g_t  led_g;
  minimig_de1_pkg::led_r_t  led_r;

  logic [31:0] rng = 32'h7df7_77fd;                     // xorshift state
  logic [29:0] exp_q [$];                               // Expected {left, right} pairs
  int          credits       = minimig_de1_pkg::SAMPLE_CREDITS;
  int          credit_pulses = 0;
  int          frames_seen   = 0;
  int          cycles        = 0;

  minimig_de1_glue i_minimig_de1_glue (.*);

  ////////////////////////////////////////
  // Helpers and reference models

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      fail_run($sformatf("Fail %s: got 0x%0h, expected 0x%0h", name, got, want));
    end
  endtask

  task automatic step();
    @(posedge clk);
    #DRIVE_DLY;                                          // Drive point after the edge
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Hex digit as active-low segments g..a
  function automatic logic [6:0] seg_ref(input logic [3:0] n);
    logic [6:0] on;
    case (n)
      4'h0: on = 7'h3f;
      4'h1: on = 7'h06;
      4'h2: on = 7'h5b;
      4'h3: on = 7'h4f;
      4'h4: on = 7'h66;
      4'h5: on = 7'h6d;
      4'h6: on = 7'h7d;
      4'h7: on = 7'h07;
      4'h8: on = 7'h7f;
      4'h9: on = 7'h6f;
      4'ha: on = 7'h77;
      4'hb: on = 7'h7c;
      4'hc: on = 7'h39;
      4'hd: on = 7'h5e;
      4'he: on = 7'h79;
      default: on = 7'h71;
    endcase
    return ~on;
  endfunction

  // Exchange first and then own minus own quarter plus other quarter
  function automatic logic [29:0] ref_pair(input logic [14:0] l, input logic [14:0] r,
                                           input logic ex, input logic mx);
    logic [14:0] a;
    logic [14:0] b;
    logic [14:0] qa;
    logic [14:0] qb;
    a  = ex ? r : l;
    b  = ex ? l : r;
    qa = {{2{a[14]}}, a[14:2]};                          // Sign-filled shift by two
    qb = {{2{b[14]}}, b[14:2]};
    if (mx) begin
      return {15'(a - qa + qb), 15'(b - qb + qa)};
    end
    return {a, b};
  endfunction

  ////////////////////////////////////////
  // Clock, timeout, credit bookkeeping

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles > MAX_CYCLES) begin
      fail_run($sformatf("Timeout after %0d cycles, %0d of %0d frames seen",
                         cycles, frames_seen, N_FRAMES));
    end
  end

  // A credit pulse in one cycle is usable in the next
  always @(posedge clk) begin
    if (rst_n) begin
      credits = credits + int'(sample_credit) - int'(sample_valid);
      if (sample_credit) begin
        credit_pulses++;
      end
      if (credits < 0 || credits > minimig_de1_pkg::SAMPLE_CREDITS) begin
        fail_run($sformatf("Source credit count left its range, now %0d", credits));
      end
    end
  end

  ////////////////////////////////////////
  // CODEC frame monitor

  initial begin : frame_monitor
    logic [31:0] got;
    logic [29:0] pair;
    forever begin
      for (int i = 31; i >= 0; i--) begin
        @(posedge aud_bclk);                             // Data stable on rising bit clock
        got[i] = aud_dacdat;
        check_eq("aud_daclrck", aud_daclrck, i >= 16);  // Left half first
      end
      if (exp_q.size() == 0) begin
        fail_run("A frame came out of the CODEC lines with no pair sent");
      end
      pair = exp_q.pop_front();
      check_eq("aud_dacdat", got, {pair[29:15], 1'b0, pair[14:0], 1'b0});
      frames_seen++;
    end
  end

  ////////////////////////////////////////
  // Stimulus

  initial begin : stimulus
    logic [3:0] act;
    rst_n        = 1'b0;
    sw           = '0;
    key          = 4'hf;                                 // Buttons released
    spi_cs0_n    = 1'b1;
    sd_dat       = 1'b0;
    core_sdo     = 1'b0;
    sample_valid = 1'b0;
    ldata        = '0;
    rdata        = '0;
    track        = '0;
    {floppy_fwr, floppy_frd, hd_fwr, hd_frd} = 4'b0000;
    ctrl_status  = '0;
    {rom_status, ram_status, reg_status} = 3'b000;

    // Reset state
    repeat (10) @(posedge clk);
    #DRIVE_DLY;
    check_eq("hex0", hex0, 7'h7f);
    check_eq("hex1", hex1, 7'h7f);
    check_eq("hex2", hex2, 7'h7f);
    check_eq("hex3", hex3, 7'h7f);
    rst_n = 1'b1;
    step();
    check_eq("sample_credit", sample_credit, 0);
    check_eq("aud_bclk", aud_bclk, 0);
    check_eq("aud_dacdat", aud_dacdat, 0);
    check_eq("led_g", led_g, 0);
    check_eq("led_r", led_r, 0);
    check_eq("rst_ext", rst_ext, 0);

    // Configuration decode and SPI selection
    for (int n = 0; n < N_CFG; n++) begin
      rng = xorshift32(rng);
      sw  = rng[9:0];
      key = rng[13:10];
      repeat (minimig_de1_pkg::SYNC_STAGES) begin
        step();
        rng = xorshift32(rng);
        {spi_cs0_n, sd_dat, core_sdo} = rng[2:0];
        #DRIVE_DLY;
        check_eq("spi_di", spi_di, spi_cs0_n ? core_sdo : sd_dat);
      end
      check_eq("scandoubler_dis", scandoubler_dis, sw[9]);
      check_eq("joy_emu_en", joy_emu_en, sw[8]);
      check_eq("boot_sel", boot_sel, sw[5]);
      check_eq("ctrl_cfg", ctrl_cfg, sw[4:1]);
      check_eq("rst_ext", rst_ext, !key[0]);
    end

    // Audio stream sent back to back under credits
    for (int c = 0; c < 4; c++) begin
      sw[7:6] = c[1:0];                                  // exchan, mix
      repeat (minimig_de1_pkg::SYNC_STAGES + 1) step();
      for (int n = 0; n < PAIRS_PER; n++) begin
        while (credits == 0) begin
          sample_valid = 1'b0;
          step();
        end
        rng          = xorshift32(rng);
        ldata        = rng[14:0];
        rdata        = rng[29:15];
        sample_valid = 1'b1;
        exp_q.push_back(ref_pair(rng[14:0], rng[29:15], sw[7], sw[6]));
        step();
      end
      sample_valid = 1'b0;
    end
    wait (frames_seen == N_FRAMES);
    repeat (2 * minimig_de1_pkg::BCLK_HALF) step();
    check_eq("sample_credit pulses", credit_pulses, frames_seen);
    check_eq("aud_bclk", aud_bclk, 0);                  // Parked low when empty

    // Track and status display
    for (int n = 0; n < 6; n++) begin
      rng         = xorshift32(rng);
      track       = rng[7:0];
      ctrl_status = rng[11:8];
      {rom_status, ram_status, reg_status} = rng[14:12];
      step();
      check_eq("hex0", hex0, seg_ref(track[3:0]));
      check_eq("hex1", hex1, seg_ref(track[7:4]));
      check_eq("hex2", hex2, seg_ref(ctrl_status));
      check_eq("hex3", hex3, 7'h7f);
      check_eq("led_r", led_r, {3'b000, reg_status, ram_status, rom_status, ctrl_status});
    end

    // Single pulses with led_g[3] for floppy_fwr down to led_g[0] for hd_frd
    for (int i = 0; i < 4; i++) begin
      act = 4'b0001 << i;
      {floppy_fwr, floppy_frd, hd_fwr, hd_frd} = act;
      step();
      {floppy_fwr, floppy_frd, hd_fwr, hd_frd} = 4'b0000;
      for (int k = 0; k < minimig_de1_pkg::ACT_STRETCH; k++) begin
        check_eq("led_g", led_g, {4'h0, act});
        step();
      end
      step();
      check_eq("led_g", led_g, 8'h00);
    end

    // Repeated pulses reload the hold time
    for (int p = 0; p < 3; p++) begin
      floppy_fwr = 1'b1;
      step();
      floppy_fwr = 1'b0;
      repeat (minimig_de1_pkg::ACT_STRETCH - 2) begin
        check_eq("led_g", led_g, 8'h08);
        step();
      end
    end
    repeat (minimig_de1_pkg::ACT_STRETCH) step();
    check_eq("led_g", led_g, 8'h00);

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/minimig_de1_glue.sv ====
`timescale 1ns/1ps
`default_nettype none

module minimig_de1_glue (
  // Clock, reset and raw board inputs
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [9:0]                      sw,              // Toggle switches
  input  wire [3:0]                      key,             // Push buttons
  // SPI data-in selection
  input  wire                            spi_cs0_n,
  input  wire                            sd_dat,
  input  wire                            core_sdo,
  output logic                           spi_di,
  // Configuration
  output logic                           scandoubler_dis,
  output logic                           joy_emu_en,
  output logic                           boot_sel,
  output logic                           rst_ext,
  output minimig_de1_pkg::nibble_t       ctrl_cfg,
  // Credited sample stream
  input  wire                            sample_valid,
  input  wire minimig_de1_pkg::sample_t  ldata,           // Left DAC data
  input  wire minimig_de1_pkg::sample_t  rdata,           // Right DAC data
  output logic                           sample_credit,
  // CODEC lines
  output logic                           aud_bclk,
  output logic                           aud_daclrck,
  output logic                           aud_dacdat,
  // Indicator inputs
  input  wire minimig_de1_pkg::track_t   track,
  input  wire                            floppy_fwr,
  input  wire                            floppy_frd,
  input  wire                            hd_fwr,
  input  wire                            hd_frd,
  input  wire minimig_de1_pkg::nibble_t  ctrl_status,
  input  wire                            rom_status,
  input  wire                            ram_status,
  input  wire                            reg_status,
  // Indicator outputs
  output minimig_de1_pkg::seg7_t         hex0,
  output minimig_de1_pkg::seg7_t         hex1,
  output minimig_de1_pkg::seg7_t         hex2,
  output minimig_de1_pkg::seg7_t         hex3,
  output minimig_de1_pkg::led_g_t        led_g,
  output minimig_de1_pkg::led_r_t        led_r
);

  logic                     exchan;                      // Synchronized SW7
  logic                     mix;                         // Synchronized SW6
  logic                     mix_valid;
  minimig_de1_pkg::sample_t mix_l;
  minimig_de1_pkg::sample_t mix_r;

  ////////////////////////////////////////
  // Board inputs

  board_io i_board_io (
    .clk             (clk            ),
    .rst_n           (rst_n          ),
    .sw              (sw             ),
    .key             (key            ),
    .spi_cs0_n       (spi_cs0_n      ),
    .sd_dat          (sd_dat         ),
    .core_sdo        (core_sdo       ),
    .scandoubler_dis (scandoubler_dis),
    .joy_emu_en      (joy_emu_en     ),
    .exchan          (exchan         ),
    .mix             (mix            ),
    .boot_sel        (boot_sel       ),
    .ctrl_cfg        (ctrl_cfg       ),
    .rst_ext         (rst_ext        ),
    .spi_di          (spi_di         )
  );

  ////////////////////////////////////////
  // Audio path

  audio_mixer i_audio_mixer (
    .clk          (clk         ),
    .rst_n        (rst_n       ),
    .exchan       (exchan      ),
    .mix          (mix         ),
    .sample_valid (sample_valid),
    .ldata        (ldata       ),
    .rdata        (rdata       ),
    .mix_valid    (mix_valid   ),
    .mix_l        (mix_l       ),
    .mix_r        (mix_r       )
  );

  audio_shifter i_audio_shifter (
    .clk           (clk          ),
    .rst_n         (rst_n        ),
    .mix_valid     (mix_valid    ),
    .mix_l         (mix_l        ),
    .mix_r         (mix_r        ),
    .sample_credit (sample_credit),                     // Straight back to the source
    .aud_bclk      (aud_bclk     ),
    .aud_daclrck   (aud_daclrck  ),
    .aud_dacdat    (aud_dacdat   )
  );

  ////////////////////////////////////////
  // Displays and LEDs

  indicators i_indicators (
    .clk         (clk        ),
    .rst_n       (rst_n      ),
    .track       (track      ),
    .ctrl_status (ctrl_status),
    .floppy_fwr  (floppy_fwr ),
    .floppy_frd  (floppy_frd ),
    .hd_fwr      (hd_fwr     ),
    .hd_frd      (hd_frd     ),
    .rom_status  (rom_status ),
    .ram_status  (ram_status ),
    .reg_status  (reg_status ),
    .hex0        (hex0       ),
    .hex1        (hex1       ),
    .hex2        (hex2       ),
    .hex3        (hex3       ),
    .led_g       (led_g      ),
    .led_r       (led_r      )
  );

endmodule

`default_nettype wire

// ==== rtl/indicators.sv ====
`timescale 1ns/1ps
`default_nettype none

module indicators (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire minimig_de1_pkg::track_t   track,        // Floppy track number
  input  wire minimig_de1_pkg::nibble_t  ctrl_status,  // Controller LEDs
  input  wire                            floppy_fwr,   // Floppy FIFO write
  input  wire                            floppy_frd,   // Floppy FIFO read
  input  wire                            hd_fwr,       // HD FIFO write
  input  wire                            hd_frd,       // HD FIFO read
  input  wire                            rom_status,   // ROM slave activity
  input  wire                            ram_status,   // RAM slave activity
  input  wire                            reg_status,   // REG slave activity
  output minimig_de1_pkg::seg7_t         hex0,
  output minimig_de1_pkg::seg7_t         hex1,
  output minimig_de1_pkg::seg7_t         hex2,
  output minimig_de1_pkg::seg7_t         hex3,
  output minimig_de1_pkg::led_g_t        led_g,
  output minimig_de1_pkg::led_r_t        led_r
);

  ////////////////////////////////////////
  // Seven-segment digits and red LEDs

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hex0  <= minimig_de1_pkg::SEG_BLANK;
      hex1  <= minimig_de1_pkg::SEG_BLANK;
      hex2  <= minimig_de1_pkg::SEG_BLANK;
      led_r <= '0;
    end else begin
      hex0  <= minimig_de1_pkg::seven_seg(track[3:0]);  // Track low digit
      hex1  <= minimig_de1_pkg::seven_seg(track[7:4]);  // Track high digit
      hex2  <= minimig_de1_pkg::seven_seg(ctrl_status);
      led_r <= {3'b000, reg_status, ram_status, rom_status, ctrl_status};
    end
  end

  assign hex3 = minimig_de1_pkg::SEG_BLANK;             // Spare digit

  ////////////////////////////////////////
  // FIFO activity stretch

  logic [3:0]                 act_in;                   // Raw pulses
  logic [3:0]                 act_on;                   // Stretched
  minimig_de1_pkg::stretch_t  act_cnt_q [4];

  assign act_in = {floppy_fwr, floppy_frd, hd_fwr, hd_frd};

  // Every pulse reloads the hold time
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 4; i++) begin
        act_cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (act_in[i]) begin
          act_cnt_q[i] <= minimig_de1_pkg::stretch_t'(minimig_de1_pkg::ACT_STRETCH);
        end else if (act_cnt_q[i] != '0) begin
          act_cnt_q[i] <= act_cnt_q[i] - 1'b1;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      act_on[i] = (act_cnt_q[i] != '0);
    end
  end

  assign led_g = {4'b0000, act_on};                     // Upper greens unused

endmodule

`default_nettype wire

// ==== rtl/audio_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_shifter (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            mix_valid,     // Pair from the mixer
  input  wire minimig_de1_pkg::sample_t  mix_l,
  input  wire minimig_de1_pkg::sample_t  mix_r,
  output logic                           sample_credit, // Pulses with each pop
  output logic                           aud_bclk,
  output logic                           aud_daclrck,   // High for left channel
  output logic                           aud_dacdat
);

  ////////////////////////////////////////
  // Pair buffer

  minimig_de1_pkg::sample_t  buf_l [minimig_de1_pkg::SAMPLE_CREDITS];
  minimig_de1_pkg::sample_t  buf_r [minimig_de1_pkg::SAMPLE_CREDITS];
  minimig_de1_pkg::buf_ptr_t wr_ptr_q;
  minimig_de1_pkg::buf_ptr_t rd_ptr_q;
  minimig_de1_pkg::buf_cnt_t cnt_q;                    // Pairs held
  minimig_de1_pkg::frame_t   frame;                    // Head pair as wire bits
  logic                      pop;

  // Credits keep mix_valid away from a full buffer
  always_ff @(posedge clk) begin
    if (mix_valid) begin
      buf_l[wr_ptr_q] <= mix_l;
      buf_r[wr_ptr_q] <= mix_r;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (mix_valid) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + minimig_de1_pkg::buf_cnt_t'(mix_valid)
                     - minimig_de1_pkg::buf_cnt_t'(pop);
    end
  end

  assign frame = {buf_l[rd_ptr_q], {minimig_de1_pkg::SLOT_PAD{1'b0}},
                  buf_r[rd_ptr_q], {minimig_de1_pkg::SLOT_PAD{1'b0}}};

  ////////////////////////////////////////
  // Frame timing and serializer

  minimig_de1_pkg::shift_state_t state_q;
  minimig_de1_pkg::div_cnt_t     div_q;                // clk count inside a slot
  minimig_de1_pkg::slot_cnt_t    slot_q;               // Slot inside a channel
  minimig_de1_pkg::frame_t       sh_q;                 // Bits still to send
  logic                          slot_end;
  logic                          chan_end;

  assign slot_end = (div_q == 2*minimig_de1_pkg::BCLK_HALF-1);
  assign chan_end = slot_end && (slot_q == minimig_de1_pkg::CHAN_BITS-1);

  // Next pair at start-up or right at the end of a frame
  assign pop = (cnt_q != '0) &&
               ((state_q == minimig_de1_pkg::idle) ||
                (state_q == minimig_de1_pkg::right && chan_end));

  assign sample_credit = pop;                          // Slot freed, credit back
  assign aud_daclrck   = (state_q == minimig_de1_pkg::left);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= minimig_de1_pkg::idle;
      div_q      <= '0;
      slot_q     <= '0;
      aud_bclk   <= 1'b0;
      aud_dacdat <= 1'b0;
    end else if (pop) begin
      state_q    <= minimig_de1_pkg::left;             // Frame starts on left MSB
      div_q      <= '0;
      slot_q     <= '0;
      aud_bclk   <= 1'b0;
      aud_dacdat <= frame[$bits(minimig_de1_pkg::frame_t)-1];
    end else if (state_q != minimig_de1_pkg::idle) begin
      div_q <= div_q + 1'b1;
      if (div_q == minimig_de1_pkg::BCLK_HALF-1) begin
        aud_bclk <= 1'b1;                              // Rising edge mid-slot
      end
      if (slot_end) begin
        div_q      <= '0;
        aud_bclk   <= 1'b0;                            // Falling edge, data moves
        slot_q     <= slot_q + 1'b1;
        aud_dacdat <= sh_q[$bits(minimig_de1_pkg::frame_t)-1]; // Zero after last slot
        if (chan_end) begin
          slot_q  <= '0;
          state_q <= (state_q == minimig_de1_pkg::left) ? minimig_de1_pkg::right
                                                        : minimig_de1_pkg::idle;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      sh_q <= frame << 1;                              // MSB already on the line
    end else if (slot_end) begin
      sh_q <= sh_q << 1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/audio_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module audio_mixer (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire                            exchan,        // Swap left and right
  input  wire                            mix,           // Blend a quarter across
  input  wire                            sample_valid,  // Spends one source credit
  input  wire minimig_de1_pkg::sample_t  ldata,
  input  wire minimig_de1_pkg::sample_t  rdata,
  output logic                           mix_valid,     // One cycle after sample_valid
  output minimig_de1_pkg::sample_t       mix_l,
  output minimig_de1_pkg::sample_t       mix_r
);

  minimig_de1_pkg::sample_t own_l;                     // After exchange
  minimig_de1_pkg::sample_t own_r;
  minimig_de1_pkg::sample_t new_l;                     // After centre mix
  minimig_de1_pkg::sample_t new_r;

  always_comb begin
    own_l = exchan ? rdata : ldata;
    own_r = exchan ? ldata : rdata;
    if (mix) begin
      new_l = own_l - (own_l >>> 2) + (own_r >>> 2);   // Wraps at 15 bits
      new_r = own_r - (own_r >>> 2) + (own_l >>> 2);
    end else begin
      new_l = own_l;
      new_r = own_r;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mix_valid <= 1'b0;
    end else begin
      mix_valid <= sample_valid;
    end
  end

  // Payload only loads on an accepted pair
  always_ff @(posedge clk) begin
    if (sample_valid) begin
      mix_l <= new_l;
      mix_r <= new_r;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/board_io.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_io (
  input  wire                            clk,
  input  wire                            rst_n,
  input  wire [9:0]                      sw,              // Toggle switches, sw[0] unused here
  input  wire [3:0]                      key,             // Push buttons, low when pressed
  input  wire                            spi_cs0_n,       // SD card select
  input  wire                            sd_dat,          // SD card MISO
  input  wire                            core_sdo,        // Core serial out
  output logic                           scandoubler_dis,
  output logic                           joy_emu_en,
  output logic                           exchan,          // Audio channel swap
  output logic                           mix,             // Audio centre mix
  output logic                           boot_sel,
  output minimig_de1_pkg::nibble_t       ctrl_cfg,
  output logic                           rst_ext,
  output logic                           spi_di
);

  ////////////////////////////////////////
  // Synchronizer chain

  logic [12:0] sync_q [minimig_de1_pkg::SYNC_STAGES]; // {key[3:0], sw[9:1]} per stage
  logic [12:0] sync_o;                                 // Last stage

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < minimig_de1_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= {4'hf, 9'h000};                    // Keys released, switches off
      end
    end else begin
      sync_q[0] <= {key, sw[9:1]};                     // Asynchronous pins in
      for (int i = 1; i < minimig_de1_pkg::SYNC_STAGES; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  assign sync_o = sync_q[minimig_de1_pkg::SYNC_STAGES-1];

  ////////////////////////////////////////
  // Configuration decode

  assign scandoubler_dis = sync_o[8];                  // SW9
  assign joy_emu_en      = sync_o[7];                  // SW8
  assign exchan          = sync_o[6];                  // SW7
  assign mix             = sync_o[5];                  // SW6
  assign boot_sel        = sync_o[4];                  // SW5
  assign ctrl_cfg        = sync_o[3:0];                // SW4..1
  assign rst_ext         = !sync_o[9];                 // KEY0 pressed

  // SD card owns MISO while selected
  assign spi_di = !spi_cs0_n ? sd_dat : core_sdo;

endmodule

`default_nettype wire

// ==== rtl/minimig_de1_pkg.sv ====
`default_nettype none

package minimig_de1_pkg;

  ////////////////////////////////////////
  // Board and stream widths

  typedef logic signed [14:0] sample_t;   // One DAC channel
  typedef logic [7:0]         track_t;    // Floppy track number
  typedef logic [6:0]         seg7_t;     // Segments g..a, active low
  typedef logic [7:0]         led_g_t;
  typedef logic [9:0]         led_r_t;
  typedef logic [3:0]         nibble_t;   // Status or config nibble

  localparam int SYNC_STAGES    = 2;      // Flops per input synchronizer
  localparam int SAMPLE_CREDITS = 2;      // Also the pair buffer depth
  localparam int BCLK_HALF      = 4;      // clk cycles per bit clock half
  localparam int CHAN_BITS      = 16;     // Bit slots per channel
  localparam int ACT_STRETCH    = 8;      // LED hold after last pulse

  localparam seg7_t SEG_BLANK = 7'h7f;    // All segments dark

  // Zero slots after each MSB-first sample
  localparam int SLOT_PAD = CHAN_BITS - $bits(sample_t);

  ////////////////////////////////////////
  // Counter and frame types

  typedef logic [2*CHAN_BITS-1:0]              frame_t;    // Left then right on the wire
  typedef logic [$clog2(SAMPLE_CREDITS)-1:0]   buf_ptr_t;
  typedef logic [$clog2(SAMPLE_CREDITS+1)-1:0] buf_cnt_t;  // 0 up to full
  typedef logic [$clog2(2*BCLK_HALF)-1:0]      div_cnt_t;  // Position inside one slot
  typedef logic [$clog2(CHAN_BITS)-1:0]        slot_cnt_t; // Slot inside one channel
  typedef logic [$clog2(ACT_STRETCH+1)-1:0]    stretch_t;

  typedef enum logic [1:0] {
    idle,                                 // No frame, bit clock parked low
    left,                                 // LR clock high
    right                                 // LR clock low
  } shift_state_t;

  // Hex digit patterns for the DE1 displays
  function automatic seg7_t seven_seg(input nibble_t n);
    case (n)
      4'h0:    return 7'h40;
      4'h1:    return 7'h79;
      4'h2:    return 7'h24;
      4'h3:    return 7'h30;
      4'h4:    return 7'h19;
      4'h5:    return 7'h12;
      4'h6:    return 7'h02;
      4'h7:    return 7'h78;
      4'h8:    return 7'h00;
      4'h9:    return 7'h10;
      4'ha:    return 7'h08;
      4'hb:    return 7'h03;
      4'hc:    return 7'h46;
      4'hd:    return 7'h21;
      4'he:    return 7'h06;
      default: return 7'h0e;              // F
    endcase
  endfunction

endpackage

`default_nettype wire
